// ==== verilog/core_bus_pkg.sv ====
`default_nettype none

package core_bus_pkg;

    // Bus geometry, fixed by the 32-bit instruction set
    parameter int BUS_W  = 32;
    parameter int STRB_W = BUS_W / 8;

    // Major opcodes of the supported subset
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_ADDI   = 7'b0010011; // OP-IMM group
    parameter logic [6:0] OP_ADD    = 7'b0110011; // OP group
    parameter logic [6:0] OP_LOAD   = 7'b0000011;
    parameter logic [6:0] OP_STORE  = 7'b0100011;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;
    parameter logic [6:0] OP_JAL    = 7'b1101111;

    // Store widths
    parameter logic [2:0] F3_SB = 3'b000;
    parameter logic [2:0] F3_SW = 3'b010;

    // Only BEQ is decoded in the branch group
    parameter logic [2:0] F3_BEQ = 3'b000;

    // Default pc after reset
    parameter logic [BUS_W-1:0] RESET_ADDR_DEF = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== verilog/rv_mini_core.sv ====
`default_nettype none

module rv_mini_core #(
    parameter logic [core_bus_pkg::BUS_W-1:0] RESET_ADDR = core_bus_pkg::RESET_ADDR_DEF
) (
    input  wire logic                              clk_core,
    input  wire logic                              arst_n_i,

    // Instruction fetch side
    output logic                                   fetch_req_o,
    output logic [core_bus_pkg::BUS_W-1:0]         fetch_addr_o,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    fetch_data_i,
    input  wire logic                              fetch_ack_i,

    // Load/store side
    output logic                                   mem_req_o,
    output logic [core_bus_pkg::BUS_W-1:0]         read_addr_o,
    output logic [core_bus_pkg::BUS_W-1:0]         write_addr_o,
    output logic [core_bus_pkg::BUS_W-1:0]         write_data_o,
    output logic [core_bus_pkg::STRB_W-1:0]        write_mask_o,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    mem_read_data_i,
    input  wire logic                              mem_ack_i
);

    import core_bus_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_MEM
    } state_t;

    state_t state;

    logic [BUS_W-1:0]  pc;
    logic [BUS_W-1:0]  instr;  // Held from fetch until the next fetch
    logic [BUS_W-1:0]  raddr_q;
    logic [BUS_W-1:0]  waddr_q;
    logic [BUS_W-1:0]  wdata_q;
    logic [STRB_W-1:0] mask_q;

    logic [BUS_W-1:0]  regs [0:31];

    // Instruction fields
    logic [6:0]        opcode;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [2:0]        funct3;

    logic [BUS_W-1:0]  imm_i;
    logic [BUS_W-1:0]  imm_s;
    logic [BUS_W-1:0]  imm_b;
    logic [BUS_W-1:0]  imm_j;
    logic [BUS_W-1:0]  imm_u;

    logic [BUS_W-1:0]  rs1_val;
    logic [BUS_W-1:0]  rs2_val;
    logic [BUS_W-1:0]  ld_addr;
    logic [BUS_W-1:0]  st_addr;
    logic [BUS_W-1:0]  pc_next;

    logic              wb_en;
    logic [BUS_W-1:0]  wb_data;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};

    // x0 always reads as zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign ld_addr = rs1_val + imm_i;
    assign st_addr = rs1_val + imm_s;

    // Next pc, only meaningful in S_EXEC
    always_comb begin
        pc_next = pc + 32'd4;
        if (opcode == OP_JAL) begin
            pc_next = pc + imm_j;
        end else if (opcode == OP_BRANCH && funct3 == F3_BEQ && rs1_val == rs2_val) begin
            pc_next = pc + imm_b;
        end
    end

    // Register write back, ALU results in S_EXEC and load data on mem_ack
    always_comb begin
        wb_en   = 1'b0;
        wb_data = '0;
        if (state == S_EXEC) begin
            case (opcode)
                OP_LUI: begin
                    wb_en   = 1'b1;
                    wb_data = imm_u;
                end
                OP_ADDI: begin
                    wb_en   = 1'b1;
                    wb_data = rs1_val + imm_i;
                end
                OP_ADD: begin
                    wb_en   = 1'b1;
                    wb_data = rs1_val + rs2_val;
                end
                OP_JAL: begin
                    wb_en   = 1'b1;
                    wb_data = pc + 32'd4;  // Link address
                end
                default: begin
                    wb_en   = 1'b0;
                end
            endcase
        end else if (state == S_MEM && mem_ack_i && opcode == OP_LOAD) begin
            wb_en   = 1'b1;
            wb_data = mem_read_data_i;
        end
    end

    always_ff @(posedge clk_core) begin
        if (wb_en && rd != 5'd0) begin
            regs[rd] <= wb_data;
        end
    end

    // Sequencer
    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= S_IDLE;
            pc    <= RESET_ADDR;
        end else begin
            case (state)
                S_IDLE: state <= S_FETCH;
                S_FETCH: begin
                    if (fetch_ack_i) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    pc <= pc_next;
                    if (opcode == OP_LOAD) begin
                        state <= S_MEM;
                    end else if (opcode == OP_STORE &&
                                 (funct3 == F3_SW || funct3 == F3_SB)) begin
                        state <= S_MEM;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (mem_ack_i) begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Instruction and memory request payload
    always_ff @(posedge clk_core) begin
        if (state == S_FETCH && fetch_ack_i) begin
            instr <= fetch_data_i;
        end
        if (state == S_EXEC) begin
            raddr_q <= ld_addr;
            waddr_q <= st_addr;
            if (opcode == OP_STORE && funct3 == F3_SB) begin
                mask_q  <= 4'b0001 << st_addr[1:0];  // Lane picked by low bits
                wdata_q <= {4{rs2_val[7:0]}};
            end else if (opcode == OP_STORE) begin
                mask_q  <= 4'b1111;
                wdata_q <= rs2_val;
            end else begin
                mask_q  <= '0;  // Load
                wdata_q <= '0;
            end
        end
    end

    assign fetch_req_o  = (state == S_FETCH);
    assign fetch_addr_o = pc;

    assign mem_req_o    = (state == S_MEM);
    assign read_addr_o  = raddr_q;
    assign write_addr_o = waddr_q;
    assign write_data_o = wdata_q;
    assign write_mask_o = (state == S_MEM) ? mask_q : '0;

    // Requests hold until the bus port acknowledges them
    a_fetch_hold: assert property (
        @(posedge clk_core) disable iff (!arst_n_i)
        fetch_req_o && !fetch_ack_i |=> fetch_req_o && $stable(fetch_addr_o)
    );

    a_mem_hold: assert property (
        @(posedge clk_core) disable iff (!arst_n_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(read_addr_o)
            && $stable(write_addr_o) && $stable(write_mask_o)
    );

endmodule

`default_nettype wire

// ==== verilog/instr_bus_port.sv ====
`default_nettype none

module instr_bus_port (
    input  wire logic                              clk_core,
    input  wire logic                              arst_n_i,

    input  wire logic                              fetch_req_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    fetch_addr_i,
    output logic [core_bus_pkg::BUS_W-1:0]         fetch_data_o,
    output logic                                   fetch_ack_o,

    output logic                                   ibus_cyc_o,
    output logic                                   ibus_stb_o,
    output logic                                   ibus_we_o,
    output logic [core_bus_pkg::STRB_W-1:0]        ibus_wstrb_o,
    output logic [core_bus_pkg::BUS_W-1:0]         ibus_addr_o,
    output logic [core_bus_pkg::BUS_W-1:0]         ibus_data_o,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    ibus_data_i,
    input  wire logic                              ibus_ack_i
);

    import core_bus_pkg::*;

    logic done;  // High the cycle after a bus ack

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done <= 1'b0;
        end else begin
            done <= ibus_ack_i;
        end
    end

    always_ff @(posedge clk_core) begin
        if (ibus_ack_i) begin
            fetch_data_o <= ibus_data_i;
        end
    end

    assign fetch_ack_o = done;

    // Request still high while the core sees the ack, so mask it off
    assign ibus_cyc_o   = fetch_req_i & ~done;
    assign ibus_stb_o   = ibus_cyc_o;
    assign ibus_we_o    = 1'b0;                 // Fetch is read only
    assign ibus_wstrb_o = {STRB_W{1'b0}};
    assign ibus_addr_o  = fetch_addr_i;
    assign ibus_data_o  = {BUS_W{1'b0}};

    a_ack_pulse: assert property (
        @(posedge clk_core) disable iff (!arst_n_i)
        fetch_ack_o |=> !fetch_ack_o
    );

endmodule

`default_nettype wire

// ==== verilog/data_bus_port.sv ====
`default_nettype none

module data_bus_port (
    input  wire logic                              clk_core,
    input  wire logic                              arst_n_i,

    // Core side, split addresses as the core produces them
    input  wire logic                              mem_req_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    read_addr_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    write_addr_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    write_data_i,
    input  wire logic [core_bus_pkg::STRB_W-1:0]   write_mask_i,
    output logic [core_bus_pkg::BUS_W-1:0]         read_data_o,
    output logic                                   mem_ack_o,

    // Data bus master
    output logic                                   dbus_cyc_o,
    output logic                                   dbus_stb_o,
    output logic                                   dbus_we_o,
    output logic [core_bus_pkg::STRB_W-1:0]        dbus_wstrb_o,
    output logic [core_bus_pkg::BUS_W-1:0]         dbus_addr_o,
    output logic [core_bus_pkg::BUS_W-1:0]         dbus_data_o,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    dbus_data_i,
    input  wire logic                              dbus_ack_i
);

    logic done;
    logic is_write;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done <= 1'b0;
        end else begin
            done <= dbus_ack_i;
        end
    end

    // Load data captured on the bus ack
    always_ff @(posedge clk_core) begin
        if (dbus_ack_i) begin
            read_data_o <= dbus_data_i;
        end
    end

    assign mem_ack_o = done;

    // Any mask bit set means a write
    assign is_write = |write_mask_i;

    assign dbus_cyc_o   = mem_req_i & ~done;
    assign dbus_stb_o   = dbus_cyc_o;
    assign dbus_we_o    = dbus_cyc_o & is_write;
    assign dbus_wstrb_o = write_mask_i;
    assign dbus_addr_o  = is_write ? write_addr_i : read_addr_i;
    assign dbus_data_o  = write_data_i;

    // A write keeps cyc, we and its lanes up to the bus ack
    a_we_in_cyc: assert property (
        @(posedge clk_core) disable iff (!arst_n_i)
        dbus_we_o && !dbus_ack_i |=> dbus_cyc_o && dbus_we_o && $stable(dbus_wstrb_o)
    );

endmodule

`default_nettype wire

// ==== verilog/core_wrapper_top.sv ====
`default_nettype none

module core_wrapper_top #(
    parameter logic [core_bus_pkg::BUS_W-1:0] RESET_ADDR = core_bus_pkg::RESET_ADDR_DEF
) (
    input  wire logic                              clk_core,
    input  wire logic                              arst_n_i,

    // Instruction bus
    output logic                                   ibus_cyc_o,
    output logic                                   ibus_stb_o,
    output logic                                   ibus_we_o,
    output logic [core_bus_pkg::STRB_W-1:0]        ibus_wstrb_o,
    output logic [core_bus_pkg::BUS_W-1:0]         ibus_addr_o,
    output logic [core_bus_pkg::BUS_W-1:0]         ibus_data_o,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    ibus_data_i,
    input  wire logic                              ibus_ack_i,

    // Data bus
    output logic                                   dbus_cyc_o,
    output logic                                   dbus_stb_o,
    output logic                                   dbus_we_o,
    output logic [core_bus_pkg::STRB_W-1:0]        dbus_wstrb_o,
    output logic [core_bus_pkg::BUS_W-1:0]         dbus_addr_o,
    output logic [core_bus_pkg::BUS_W-1:0]         dbus_data_o,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    dbus_data_i,
    input  wire logic                              dbus_ack_i
);

    import core_bus_pkg::*;

    // Core to instruction port
    logic              fetch_req;
    logic [BUS_W-1:0]  fetch_addr;
    logic [BUS_W-1:0]  fetch_data;
    logic              fetch_ack;

    // Core to data port
    logic              mem_req;
    logic [BUS_W-1:0]  read_addr;
    logic [BUS_W-1:0]  write_addr;
    logic [BUS_W-1:0]  write_data;
    logic [STRB_W-1:0] write_mask;
    logic [BUS_W-1:0]  mem_read_data;
    logic              mem_ack;

    rv_mini_core #(
        .RESET_ADDR      (RESET_ADDR)
    ) rv_mini_core_inst (
        .clk_core        (clk_core),
        .arst_n_i        (arst_n_i),
        .fetch_req_o     (fetch_req),
        .fetch_addr_o    (fetch_addr),
        .fetch_data_i    (fetch_data),
        .fetch_ack_i     (fetch_ack),
        .mem_req_o       (mem_req),
        .read_addr_o     (read_addr),
        .write_addr_o    (write_addr),
        .write_data_o    (write_data),
        .write_mask_o    (write_mask),
        .mem_read_data_i (mem_read_data),
        .mem_ack_i       (mem_ack)
    );

    instr_bus_port instr_bus_port_inst (
        .clk_core        (clk_core),
        .arst_n_i        (arst_n_i),
        .fetch_req_i     (fetch_req),
        .fetch_addr_i    (fetch_addr),
        .fetch_data_o    (fetch_data),
        .fetch_ack_o     (fetch_ack),
        .ibus_cyc_o      (ibus_cyc_o),
        .ibus_stb_o      (ibus_stb_o),
        .ibus_we_o       (ibus_we_o),
        .ibus_wstrb_o    (ibus_wstrb_o),
        .ibus_addr_o     (ibus_addr_o),
        .ibus_data_o     (ibus_data_o),
        .ibus_data_i     (ibus_data_i),
        .ibus_ack_i      (ibus_ack_i)
    );

    data_bus_port data_bus_port_inst (
        .clk_core        (clk_core),
        .arst_n_i        (arst_n_i),
        .mem_req_i       (mem_req),
        .read_addr_i     (read_addr),
        .write_addr_i    (write_addr),
        .write_data_i    (write_data),
        .write_mask_i    (write_mask),
        .read_data_o     (mem_read_data),
        .mem_ack_o       (mem_ack),
        .dbus_cyc_o      (dbus_cyc_o),
        .dbus_stb_o      (dbus_stb_o),
        .dbus_we_o       (dbus_we_o),
        .dbus_wstrb_o    (dbus_wstrb_o),
        .dbus_addr_o     (dbus_addr_o),
        .dbus_data_o     (dbus_data_o),
        .dbus_data_i     (dbus_data_i),
        .dbus_ack_i      (dbus_ack_i)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model #(
    parameter int SEED = 11
) (
    input  wire logic                              clk_core,
    input  wire logic                              arst_n_i,

    input  wire logic                              ibus_cyc_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    ibus_addr_i,
    output logic [core_bus_pkg::BUS_W-1:0]         ibus_data_o,
    output logic                                   ibus_ack_o,

    input  wire logic                              dbus_cyc_i,
    input  wire logic                              dbus_we_i,
    input  wire logic [core_bus_pkg::STRB_W-1:0]   dbus_wstrb_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    dbus_addr_i,
    input  wire logic [core_bus_pkg::BUS_W-1:0]    dbus_data_i,
    output logic [core_bus_pkg::BUS_W-1:0]         dbus_data_o,
    output logic                                   dbus_ack_o
);

    import core_bus_pkg::*;

    logic [BUS_W-1:0] imem [0:63];
    logic [BUS_W-1:0] dmem [0:127];   // Byte addresses 0x000 to 0x1FF
    logic [1:0]       idelay [0:255];  // Extra ack wait per transaction
    logic [1:0]       ddelay [0:255];
    logic [1:0]       icnt;
    logic [1:0]       dcnt;
    logic [7:0]       itxn;
    logic [7:0]       dtxn;

    // Every accepted write, in bus order
    logic [BUS_W-1:0] log_addr [$];
    logic [BUS_W-1:0] log_data [$];

    function automatic logic [31:0] lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OP_ADDI};
    endfunction

    function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OP_ADD};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OP_LOAD};
    endfunction

    function automatic logic [31:0] store(input logic [2:0] f3, input int rs2,
                                          input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] beq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], F3_BEQ, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    initial begin
        void'($urandom(SEED));
        for (int k = 0; k < 256; k++) begin
            idelay[k] = 2'($urandom_range(3, 0));
            ddelay[k] = 2'($urandom_range(3, 0));
        end
        // Unused words decode as no-ops tagged with their byte address
        for (int k = 0; k < 64; k++) begin
            imem[k] = 32'(k * 4) << 7;
        end
        for (int k = 0; k < 128; k++) begin
            dmem[k] = 32'h5A5A_0000 | 32'(k * 4);
        end
        dmem[80] = 32'hCAFE_F00D;          // Load source at 0x140

        imem[0]  = lui(1, 20'h12345);
        imem[1]  = addi(1, 1, 12'h678);
        imem[2]  = addi(2, 0, 12'h100);    // Data base
        imem[3]  = store(F3_SW, 1, 2, 0);
        imem[4]  = addi(3, 0, -1);
        imem[5]  = add(4, 1, 3);
        imem[6]  = store(F3_SW, 4, 2, 4);
        imem[7]  = addi(5, 0, 12'h0A5);
        imem[8]  = store(F3_SB, 5, 2, 8);  // One byte per lane
        imem[9]  = store(F3_SB, 5, 2, 9);
        imem[10] = store(F3_SB, 5, 2, 10);
        imem[11] = store(F3_SB, 5, 2, 11);
        imem[12] = lw(6, 2, 12'h040);
        imem[13] = store(F3_SW, 6, 2, 12);
        imem[14] = addi(9, 0, 12'h7EE);    // Marker value
        imem[15] = beq(0, 0, 12);
        imem[16] = store(F3_SW, 9, 2, 16);
        imem[17] = store(F3_SW, 9, 2, 20);
        imem[18] = jal(10, 12);
        imem[19] = store(F3_SW, 9, 2, 24);
        imem[20] = store(F3_SW, 9, 2, 28);
        imem[21] = store(F3_SW, 10, 2, 16); // Link address
        imem[22] = store(F3_SW, 2, 2, 32);  // Closing store
        imem[23] = jal(0, 0);              // Spin here
    end

    always @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ibus_ack_o  <= 1'b0;
            ibus_data_o <= '0;
            icnt        <= '0;
            itxn        <= '0;
        end else if (ibus_ack_o) begin
            ibus_ack_o <= 1'b0;
            icnt       <= '0;
            itxn       <= itxn + 1'b1;
        end else if (ibus_cyc_i) begin
            if (icnt == idelay[itxn]) begin
                ibus_ack_o  <= 1'b1;
                ibus_data_o <= imem[ibus_addr_i[7:2]];
            end else begin
                icnt <= icnt + 1'b1;
            end
        end
    end

    always @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dbus_ack_o  <= 1'b0;
            dbus_data_o <= '0;
            dcnt        <= '0;
            dtxn        <= '0;
        end else if (dbus_ack_o) begin
            dbus_ack_o <= 1'b0;
            dcnt       <= '0;
            dtxn       <= dtxn + 1'b1;
        end else if (dbus_cyc_i) begin
            if (dcnt == ddelay[dtxn]) begin
                dbus_ack_o  <= 1'b1;
                dbus_data_o <= dmem[dbus_addr_i[8:2]];
                if (dbus_we_i) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (dbus_wstrb_i[b]) begin
                            dmem[dbus_addr_i[8:2]][8*b +: 8] <= dbus_data_i[8*b +: 8];
                        end
                    end
                    log_addr.push_back(dbus_addr_i);
                    log_data.push_back(dbus_data_i);
                end
            end else begin
                dcnt <= dcnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_core_wrapper.sv ====
`default_nettype none

module tb_core_wrapper;

    import core_bus_pkg::*;

    localparam logic [BUS_W-1:0] RESET_ADDR = RESET_ADDR_DEF;
    localparam logic [BUS_W-1:0] MARKER     = 32'h0000_07EE;
    localparam int               N_WRITES   = 9;
    localparam int               RAND_SEED  = 11;

    logic              clk_core;
    logic              arst_n;
    logic              ibus_cyc;
    logic              ibus_stb;
    logic              ibus_we;
    logic [STRB_W-1:0] ibus_wstrb;
    logic [BUS_W-1:0]  ibus_addr;
    logic [BUS_W-1:0]  ibus_wdata;
    logic [BUS_W-1:0]  ibus_rdata;
    logic              ibus_ack;
    logic              dbus_cyc;
    logic              dbus_stb;
    logic              dbus_we;
    logic [STRB_W-1:0] dbus_wstrb;
    logic [BUS_W-1:0]  dbus_addr;
    logic [BUS_W-1:0]  dbus_wdata;
    logic [BUS_W-1:0]  dbus_rdata;
    logic              dbus_ack;

    int errors       = 0;
    int fetch_seen   = 0;  // Completed ibus cycles
    int wr_seen      = 0;  // Completed dbus writes
    int tests_run    = 0;
    int tests_failed = 0;
    int err_mark;
    bit ok;

    core_wrapper_top #(
        .RESET_ADDR   (RESET_ADDR)
    ) core_wrapper_top_inst (
        .clk_core     (clk_core),
        .arst_n_i     (arst_n),
        .ibus_cyc_o   (ibus_cyc),
        .ibus_stb_o   (ibus_stb),
        .ibus_we_o    (ibus_we),
        .ibus_wstrb_o (ibus_wstrb),
        .ibus_addr_o  (ibus_addr),
        .ibus_data_o  (ibus_wdata),
        .ibus_data_i  (ibus_rdata),
        .ibus_ack_i   (ibus_ack),
        .dbus_cyc_o   (dbus_cyc),
        .dbus_stb_o   (dbus_stb),
        .dbus_we_o    (dbus_we),
        .dbus_wstrb_o (dbus_wstrb),
        .dbus_addr_o  (dbus_addr),
        .dbus_data_o  (dbus_wdata),
        .dbus_data_i  (dbus_rdata),
        .dbus_ack_i   (dbus_ack)
    );

    tb_mem_model #(
        .SEED         (RAND_SEED)
    ) mem_model_inst (
        .clk_core     (clk_core),
        .arst_n_i     (arst_n),
        .ibus_cyc_i   (ibus_cyc),
        .ibus_addr_i  (ibus_addr),
        .ibus_data_o  (ibus_rdata),
        .ibus_ack_o   (ibus_ack),
        .dbus_cyc_i   (dbus_cyc),
        .dbus_we_i    (dbus_we),
        .dbus_wstrb_i (dbus_wstrb),
        .dbus_addr_i  (dbus_addr),
        .dbus_data_i  (dbus_wdata),
        .dbus_data_o  (dbus_rdata),
        .dbus_ack_o   (dbus_ack)
    );

    initial begin
        clk_core = 1'b0;
        forever #10 clk_core = ~clk_core;
    end

    always @(posedge clk_core) begin
        if (ibus_cyc && ibus_ack) begin
            fetch_seen <= fetch_seen + 1;
        end
        if (dbus_cyc && dbus_we && dbus_ack) begin
            wr_seen <= wr_seen + 1;
        end
    end

    // Straight line up to the BEQ at 0x3C, then the two jump targets
    function automatic logic [BUS_W-1:0] exp_fetch_addr(input int idx);
        logic [BUS_W-1:0] off;
        if (idx <= 15) begin
            off = 32'(idx * 4);
        end else if (idx == 16) begin
            off = 32'h48;
        end else if (idx == 17) begin
            off = 32'h54;
        end else if (idx == 18) begin
            off = 32'h58;
        end else begin
            off = 32'h5C;  // Self loop
        end
        return RESET_ADDR + off;
    endfunction

    // Expected {addr, data, wstrb} of each store in program order
    function automatic logic [67:0] exp_write(input int idx);
        case (idx)
            0:       return {32'h100, 32'h1234_5678, 4'b1111};
            1:       return {32'h104, 32'h1234_5677, 4'b1111};  // x1 + (-1)
            2:       return {32'h108, 32'hA5A5_A5A5, 4'b0001};
            3:       return {32'h109, 32'hA5A5_A5A5, 4'b0010};
            4:       return {32'h10A, 32'hA5A5_A5A5, 4'b0100};
            5:       return {32'h10B, 32'hA5A5_A5A5, 4'b1000};
            6:       return {32'h10C, 32'hCAFE_F00D, 4'b1111};
            7:       return {32'h110, RESET_ADDR + 32'h4C, 4'b1111};
            8:       return {32'h120, 32'h0000_0100, 4'b1111};
            default: return '0;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int mark, input bit done_ok);
        tests_run++;
        if (errors != mark || !done_ok) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, errors - mark);
    endtask

    task automatic wait_for_count(input bit on_dbus, input int target, input int limit,
                                  inout bit done_ok);
        int cycles;
        cycles = 0;
        while ((on_dbus ? wr_seen : fetch_seen) < target && cycles < limit) begin
            @(posedge clk_core);
            cycles++;
        end
        if ((on_dbus ? wr_seen : fetch_seen) < target) begin
            $display("timeout: %0d %s did not complete within %0d cycles",
                     target, on_dbus ? "data writes" : "fetches", limit);
            done_ok = 1'b0;
        end
    endtask

    task automatic check_write_log();
        assert (mem_model_inst.log_data.size() == N_WRITES)
            else report_error($sformatf("write log holds %0d entries",
                                        mem_model_inst.log_data.size()));
        for (int k = 0; k < mem_model_inst.log_data.size(); k++) begin
            assert (mem_model_inst.log_data[k] != MARKER)
                else report_error($sformatf("marker written to %h", mem_model_inst.log_addr[k]));
        end
        assert (mem_model_inst.dmem[66] == 32'hA5A5_A5A5)
            else report_error("byte stores did not fill word 0x108");
    endtask

    a_reset_idle: assert property (@(posedge clk_core)
        !arst_n |-> !ibus_cyc && !dbus_cyc && !dbus_we)
        else report_error("bus cycle active during reset");

    a_first_fetch: assert property (@(posedge clk_core)
        $rose(arst_n) |-> ##[0:2] (ibus_cyc && ibus_addr == RESET_ADDR))
        else report_error("first fetch late or not at reset address");

    a_ibus_hold: assert property (@(posedge clk_core) disable iff (!arst_n)
        ibus_cyc && !ibus_ack |=> ibus_cyc && $stable(ibus_addr))
        else report_error("ibus request dropped or address moved before ack");

    a_ibus_once: assert property (@(posedge clk_core) disable iff (!arst_n)
        ibus_ack |=> !ibus_cyc)
        else report_error("ibus cycle repeated right after ack");

    // Fetch is read only, so the write side of the bus stays quiet
    a_ibus_read: assert property (@(posedge clk_core) disable iff (!arst_n)
        ibus_stb == ibus_cyc && !ibus_we && ibus_wstrb == '0 && ibus_wdata == '0)
        else report_error("ibus stb, we, wstrb or write data wrong");

    a_fetch_path: assert property (@(posedge clk_core) disable iff (!arst_n)
        ibus_cyc && ibus_ack |-> ibus_addr == exp_fetch_addr(fetch_seen))
        else report_error($sformatf("fetch %0d from %h", $sampled(fetch_seen),
                                    $sampled(ibus_addr)));

    a_dbus_hold: assert property (@(posedge clk_core) disable iff (!arst_n)
        dbus_cyc && !dbus_ack |=> dbus_cyc && $stable({dbus_addr, dbus_wdata, dbus_wstrb, dbus_we}))
        else report_error("dbus request changed before ack");

    a_dbus_once: assert property (@(posedge clk_core) disable iff (!arst_n)
        dbus_ack |=> !dbus_cyc)
        else report_error("dbus cycle repeated right after ack");

    a_dbus_stb: assert property (@(posedge clk_core) disable iff (!arst_n)
        dbus_stb == dbus_cyc)
        else report_error("dbus stb differs from cyc");

    a_write_value: assert property (@(posedge clk_core) disable iff (!arst_n)
        dbus_cyc && dbus_we && dbus_ack |->
            {dbus_addr, dbus_wdata, dbus_wstrb} == exp_write(wr_seen))
        else report_error($sformatf("write %0d got addr %h data %h strb %b",
                                    $sampled(wr_seen), $sampled(dbus_addr),
                                    $sampled(dbus_wdata), $sampled(dbus_wstrb)));

    a_load_addr: assert property (@(posedge clk_core) disable iff (!arst_n)
        dbus_cyc && !dbus_we && dbus_ack |-> dbus_addr == 32'h140 && dbus_wstrb == '0)
        else report_error($sformatf("load from %h", $sampled(dbus_addr)));

    a_no_marker: assert property (@(posedge clk_core) disable iff (!arst_n)
        dbus_cyc && dbus_we |-> dbus_wdata != MARKER)
        else report_error("skipped store reached the data bus");

    initial begin
        arst_n <= 1'b0;
        ok = 1'b1;
        repeat (2) @(posedge clk_core);
        arst_n <= 1'b1;

        err_mark = errors;
        wait_for_count(1'b0, 1, 20, ok);
        end_test("reset_first_fetch", err_mark, ok);

        if (ok) begin
            err_mark = errors;
            wait_for_count(1'b1, N_WRITES, 2000, ok);
            end_test("program_stores", err_mark, ok);
        end

        if (ok) begin
            err_mark = errors;
            repeat (40) @(posedge clk_core);  // Core spins in its self loop
            check_write_log();
            end_test("write_log", err_mark, ok);
        end

        $display("summary: %0d tests run, %0d failed, %0d errors, %0d fetches, %0d writes",
                 tests_run, tests_failed, errors, fetch_seen, wr_seen);
        if (ok && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/core_bus_pkg.sv
verilog/rv_mini_core.sv
verilog/instr_bus_port.sv
verilog/data_bus_port.sv
verilog/core_wrapper_top.sv
testbench/tb_mem_model.sv
testbench/tb_core_wrapper.sv
